/* dv/executeStageTb.sv */
/*
  Testbench for the execute stage. Drives LFSR-based instructions on
  the falling clk edge and keeps its own model of the operand path,
  the ALU, the flags register and the memory stage outputs. Concurrent
  assertions compare the DUT with the model. The run goes through
  directed phases, one report line each, then a summary line.
*/
`timescale 1ns/1ps

module executeStageTb;

	localparam int msb = execPkg::dataWidth - 1;
	localparam int drainLimit = 16; // cycles allowed for the pipeline to drain

	logic clk;
	logic rstN;
	execPkg::wordT rd1, rd2, extImm, resultW, aluResultMFb;
	logic pcSrc, regWrite, memtoReg, memWrite, branch, aluSrc;
	execPkg::aluOpT aluControl;
	logic [1:0] flagWrite;
	execPkg::condT cond;
	execPkg::regIdxT wa3;
	execPkg::fwdSelT forwardA, forwardB;

	logic pcSrcM, regWriteM, memWriteM, memtoRegM, branchTaken;
	execPkg::wordT aluResultM, writeDataM, aluResultF;
	execPkg::regIdxT wa3M;
	execPkg::flagsT flags;

	// reference model
	execPkg::wordT refA, refWd, refB, refResult;
	execPkg::flagsT refFlags;
	execPkg::flagsT modelFlags;
	logic condPass;
	logic expPcSrcM, expRegWriteM, expMemWriteM, expMemtoRegM;
	execPkg::wordT expAluResultM, expWriteDataM;
	execPkg::regIdxT expWa3M;

	int memTag; // issue number of the instruction now in the memory stage
	int issuedCount;
	int errCount;
	int phaseStart;
	int phasesPassed;
	int phasesFailed;
	logic aborted;
	logic [31:0] lfsrState;

	always #50 clk = ~clk;

	executeStage DUT (
		.clk(clk), .rstN(rstN),
		.rd1(rd1), .rd2(rd2), .extImm(extImm),
		.resultW(resultW), .aluResultMFb(aluResultMFb),
		.pcSrc(pcSrc), .regWrite(regWrite), .memtoReg(memtoReg),
		.memWrite(memWrite), .branch(branch), .aluSrc(aluSrc),
		.aluControl(aluControl), .flagWrite(flagWrite), .cond(cond), .wa3(wa3),
		.forwardA(forwardA), .forwardB(forwardB),
		.pcSrcM(pcSrcM), .regWriteM(regWriteM), .memWriteM(memWriteM),
		.memtoRegM(memtoRegM), .branchTaken(branchTaken),
		.aluResultM(aluResultM), .writeDataM(writeDataM), .aluResultF(aluResultF),
		.wa3M(wa3M), .flags(flags)
	);

	function automatic logic [31:0] lfsrStep(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1); // Galois, right shift
	endfunction

	function logic [31:0] randBits(input int n);
		logic [31:0] v;
		v = '0;
		for (int i = 0; i < n; i++) begin
			v = {v[30:0], lfsrState[0]};
			lfsrState = lfsrStep(lfsrState);
		end
		return v;
	endfunction

	function automatic execPkg::wordT fwdPick(input execPkg::fwdSelT sel,
			input execPkg::wordT regVal, input execPkg::wordT wVal, input execPkg::wordT mVal);
		case (sel)
			execPkg::fwdResultW:    return wVal;
			execPkg::fwdAluResultM: return mVal;
			default:                return regVal;
		endcase
	endfunction

	// returns {N, Z, C, V, result}
	function automatic logic [msb+4:0] refAlu(input execPkg::aluOpT op,
			input execPkg::wordT a, input execPkg::wordT b);
		execPkg::wordT r;
		logic c;
		logic v;
		c = 1'b0;
		v = 1'b0;
		case (op)
			execPkg::aluAdd: begin
				{c, r} = {1'b0, a} + {1'b0, b};
				v = (a[msb] == b[msb]) && (r[msb] != a[msb]);
			end
			execPkg::aluSub: begin
				r = a - b;
				c = (a >= b); // no borrow
				v = (a[msb] != b[msb]) && (r[msb] != a[msb]);
			end
			execPkg::aluAnd: r = a & b;
			execPkg::aluOrr: r = a | b;
			execPkg::aluEor: r = a ^ b;
			execPkg::aluBic: r = a & ~b;
			execPkg::aluMov: r = b;
			default:         r = ~b;
		endcase
		return {r[msb], (r == '0), c, v, r};
	endfunction

	function automatic logic refCond(input execPkg::condT cc, input execPkg::flagsT f);
		logic n, z, c, v;
		{n, z, c, v} = f;
		case (cc)
			execPkg::condEq: return z;
			execPkg::condNe: return !z;
			execPkg::condCs: return c;
			execPkg::condCc: return !c;
			execPkg::condMi: return n;
			execPkg::condPl: return !n;
			execPkg::condVs: return v;
			execPkg::condVc: return !v;
			execPkg::condHi: return c && !z;
			execPkg::condLs: return !c || z;
			execPkg::condGe: return n == v;
			execPkg::condLt: return n != v;
			execPkg::condGt: return !z && (n == v);
			execPkg::condLe: return z || (n != v);
			execPkg::condAl: return 1'b1;
			default:         return 1'b0; // reserved
		endcase
	endfunction

	function automatic execPkg::wordT edgeVal(input int i);
		case (i)
			0:       return '0;
			1:       return '1;
			2:       return {1'b1, {msb{1'b0}}}; // top bit only
			default: return execPkg::wordT'(1);
		endcase
	endfunction

	always_comb begin
		refA = fwdPick(forwardA, rd1, resultW, aluResultMFb);
		refWd = fwdPick(forwardB, rd2, resultW, aluResultMFb);
		refB = aluSrc ? extImm : refWd;
		{refFlags, refResult} = refAlu(aluControl, refA, refB);
		condPass = refCond(cond, modelFlags);
	end

	always @(posedge clk) begin
		if (!rstN) begin
			modelFlags <= '0;
			{expPcSrcM, expRegWriteM, expMemWriteM, expMemtoRegM} <= 4'b0;
			expAluResultM <= '0;
			expWriteDataM <= '0;
			expWa3M <= '0;
			memTag <= 0;
		end else begin
			if (condPass && flagWrite[1]) begin
				modelFlags[execPkg::flagN] <= refFlags[execPkg::flagN];
				modelFlags[execPkg::flagZ] <= refFlags[execPkg::flagZ];
			end
			if (condPass && flagWrite[0]) begin
				modelFlags[execPkg::flagC] <= refFlags[execPkg::flagC];
				modelFlags[execPkg::flagV] <= refFlags[execPkg::flagV];
			end
			expPcSrcM <= pcSrc & condPass;
			expRegWriteM <= regWrite & condPass;
			expMemWriteM <= memWrite & condPass;
			expMemtoRegM <= memtoReg;
			expAluResultM <= refResult;
			expWriteDataM <= refWd;
			expWa3M <= wa3;
			memTag <= issuedCount;
		end
	end

	task automatic countError();
		errCount++;
	endtask

	cResetQuiet: assert property (@(posedge clk) $rose(rstN) |->
		(!(pcSrcM || regWriteM || memWriteM || memtoRegM) && flags == 4'h0))
		else begin
			$display("memory stage strobes or flags not clear on the first cycle after reset");
			countError();
		end
	cResultF: assert property (@(posedge clk) disable iff (!rstN) aluResultF == refResult)
		else begin
			$display("** Error aluResultF got %h expected %h at %0t",
				$sampled(aluResultF), $sampled(refResult), $time);
			countError();
		end
	cFlags: assert property (@(posedge clk) disable iff (!rstN) flags == modelFlags)
		else begin
			$display("** Error flags got %h expected %h at %0t",
				$sampled(flags), $sampled(modelFlags), $time);
			countError();
		end
	cBranch: assert property (@(posedge clk) disable iff (!rstN)
		branchTaken == (branch & condPass))
		else begin
			$display("** Error branchTaken got %h expected %h at %0t",
				$sampled(branchTaken), $sampled(branch & condPass), $time);
			countError();
		end
	cStrobes: assert property (@(posedge clk) disable iff (!rstN)
		{pcSrcM, regWriteM, memWriteM, memtoRegM} ==
		{expPcSrcM, expRegWriteM, expMemWriteM, expMemtoRegM})
		else begin
			$display("** Error {pcSrcM,regWriteM,memWriteM,memtoRegM} got %h expected %h at %0t",
				$sampled({pcSrcM, regWriteM, memWriteM, memtoRegM}),
				$sampled({expPcSrcM, expRegWriteM, expMemWriteM, expMemtoRegM}), $time);
			countError();
		end
	cResultM: assert property (@(posedge clk) disable iff (!rstN) aluResultM == expAluResultM)
		else begin
			$display("** Error aluResultM got %h expected %h at %0t",
				$sampled(aluResultM), $sampled(expAluResultM), $time);
			countError();
		end
	cWriteData: assert property (@(posedge clk) disable iff (!rstN)
		writeDataM == expWriteDataM)
		else begin
			$display("** Error writeDataM got %h expected %h at %0t",
				$sampled(writeDataM), $sampled(expWriteDataM), $time);
			countError();
		end
	cWa3: assert property (@(posedge clk) disable iff (!rstN) wa3M == expWa3M)
		else begin
			$display("** Error wa3M got %h expected %h at %0t",
				$sampled(wa3M), $sampled(expWa3M), $time);
			countError();
		end

	task automatic randomInstr();
		rd1 = execPkg::wordT'(randBits(24));
		rd2 = execPkg::wordT'(randBits(24));
		extImm = execPkg::wordT'(randBits(24));
		resultW = execPkg::wordT'(randBits(24));
		aluResultMFb = execPkg::wordT'(randBits(24));
		{pcSrc, regWrite, memtoReg, memWrite, branch, aluSrc} = 6'(randBits(6));
		aluControl = execPkg::aluOpT'(3'(randBits(3)));
		flagWrite = 2'(randBits(2));
		cond = execPkg::condT'(4'(randBits(4)));
		wa3 = execPkg::regIdxT'(randBits(4));
		forwardA = execPkg::fwdSelT'(2'(randBits(4) % 3)); // legal selects only
		forwardB = execPkg::fwdSelT'(2'(randBits(4) % 3));
		issuedCount++;
	endtask

	// put a and b into whichever sources the selects pick
	task automatic placeOperands(input execPkg::wordT a, input execPkg::wordT b);
		if (!aluSrc && forwardB == forwardA && forwardB != execPkg::fwdReg)
			forwardB = execPkg::fwdReg;
		case (forwardA)
			execPkg::fwdResultW:    resultW = a;
			execPkg::fwdAluResultM: aluResultMFb = a;
			default:                rd1 = a;
		endcase
		if (aluSrc) begin
			extImm = b;
		end else begin
			case (forwardB)
				execPkg::fwdResultW:    resultW = b;
				execPkg::fwdAluResultM: aluResultMFb = b;
				default:                rd2 = b;
			endcase
		end
	endtask

	task automatic flagCase(input execPkg::aluOpT op, input execPkg::wordT a,
			input execPkg::wordT b, input logic [1:0] fw);
		@(negedge clk);
		randomInstr();
		aluControl = op;
		cond = execPkg::condAl;
		flagWrite = fw;
		placeOperands(a, b);
	endtask

	task automatic finishPhase(input string name);
		int waited;
		int errs;
		waited = 0;
		while (memTag != issuedCount && waited < drainLimit) begin
			@(negedge clk);
			waited++;
		end
		if (memTag != issuedCount) begin
			$display("phase %s timed out, last instruction never reached the memory stage", name);
			aborted = 1'b1;
			phasesFailed++;
		end else begin
			@(negedge clk); // memory stage check of the last instruction happens at this edge
			errs = errCount - phaseStart;
			if (errs == 0)
				phasesPassed++;
			else
				phasesFailed++;
			$display("phase %s finished with %0d errors", name, errs);
		end
	endtask

	initial begin
		clk = 1'b0;
		rstN = 1'b0;
		{rd1, rd2, extImm, resultW, aluResultMFb} = '0;
		{pcSrc, regWrite, memtoReg, memWrite, branch, aluSrc} = 6'b0;
		aluControl = execPkg::aluAdd;
		flagWrite = 2'b00;
		cond = execPkg::condAl;
		wa3 = '0;
		forwardA = execPkg::fwdReg;
		forwardB = execPkg::fwdReg;
		lfsrState = 32'hbbf6;
		{issuedCount, errCount, phaseStart, phasesPassed, phasesFailed} = '0;
		aborted = 1'b0;

		// strobes held high while in reset
		repeat (10) begin
			@(negedge clk);
			randomInstr();
			{pcSrc, regWrite, memWrite, memtoReg} = 4'hf;
			cond = execPkg::condAl;
		end
		rstN = 1'b1;
		randomInstr();
		finishPhase("reset");

		if (!aborted) begin
			phaseStart = errCount;
			for (int op = 0; op < 8; op++)
				for (int i = 0; i < 4; i++)
					for (int j = 0; j < 4; j++) begin
						@(negedge clk);
						randomInstr();
						aluControl = execPkg::aluOpT'(3'(op));
						cond = execPkg::condAl;
						placeOperands(edgeVal(i), edgeVal(j));
					end
			finishPhase("alu operations");
		end

		if (!aborted) begin
			phaseStart = errCount;
			flagCase(execPkg::aluAdd, 24'h7fffff, 24'h000001, 2'b11); // N and V
			flagCase(execPkg::aluAdd, 24'hffffff, 24'h000001, 2'b11); // Z and C
			flagCase(execPkg::aluSub, 24'h000000, 24'h000001, 2'b11); // borrow
			flagCase(execPkg::aluSub, 24'h000005, 24'h000005, 2'b11);
			flagCase(execPkg::aluSub, 24'h800000, 24'h000001, 2'b11); // V on subtract
			flagCase(execPkg::aluMov, 24'h123456, 24'h000000, 2'b11);
			repeat (40) begin
				@(negedge clk);
				randomInstr();
				cond = execPkg::condAl;
				flagWrite = 2'(1 + randBits(1)); // one field group at a time
			end
			finishPhase("flag update");
		end

		if (!aborted) begin
			phaseStart = errCount;
			repeat (200) begin
				@(negedge clk);
				randomInstr();
			end
			finishPhase("conditional execution");
		end

		if (!aborted) begin
			phaseStart = errCount;
			repeat (150) begin
				@(negedge clk);
				randomInstr();
				aluResultMFb = aluResultM; // real feedback from the memory stage
			end
			finishPhase("back to back pipeline");
		end

		$display("%0d phases passed, %0d phases failed, %0d errors",
			phasesPassed, phasesFailed, errCount);
		if (aborted || errCount != 0 || phasesFailed != 0)
			$display("TEST FAIL");
		else
			$display("TEST PASS");
		$finish;
	end

endmodule

/* executeStage.f */
hdl/execPkg.sv
hdl/operandSelect.sv
hdl/alu.sv
hdl/conditionUnit.sv
hdl/executeMemReg.sv
hdl/executeStage.sv
dv/executeStageTb.sv

/* hdl/alu.sv */
/*
  Scalar ALU of the execute stage. Eight operations on two N-bit
  operands, with NZCV flags. Add and subtract share one adder; on a
  subtract C is the no-borrow bit. Logic and move operations clear
  C and V. clk and rstN only sample the assertions.
*/
`timescale 1ns/1ps

module alu #(
	parameter int N = 24
) (
	input  logic clk,
	input  logic rstN,
	input  logic [N-1:0] a,
	input  logic [N-1:0] b,
	input  execPkg::aluOpT aluControl,
	output logic [N-1:0] result,
	output execPkg::flagsT aluFlags
);

	logic isSub;
	logic isArith;
	logic [N-1:0] bOp;
	logic [N:0] sum;
	logic carry;
	logic overflow;

	assign isSub = (aluControl == execPkg::aluSub);
	assign isArith = (aluControl == execPkg::aluAdd) || isSub;

	// a - b is a + ~b + 1
	assign bOp = isSub ? ~b : b;
	assign sum = {1'b0, a} + {1'b0, bOp} + {{N{1'b0}}, isSub};

	assign carry = sum[N];
	// same sign in, different sign out
	assign overflow = ~(a[N-1] ^ bOp[N-1]) & (a[N-1] ^ sum[N-1]);

	always_comb begin
		case (aluControl)
			execPkg::aluAdd: result = sum[N-1:0];
			execPkg::aluSub: result = sum[N-1:0];
			execPkg::aluAnd: result = a & b;
			execPkg::aluOrr: result = a | b;
			execPkg::aluEor: result = a ^ b;
			execPkg::aluBic: result = a & ~b;
			execPkg::aluMov: result = b;
			execPkg::aluMvn: result = ~b;
			default:         result = '0;
		endcase
	end

	always_comb begin
		aluFlags = '0;
		aluFlags[execPkg::flagN] = result[N-1]; // sign bit
		aluFlags[execPkg::flagZ] = (result == '0);
		aluFlags[execPkg::flagC] = isArith & carry; // 0 for logic ops
		aluFlags[execPkg::flagV] = isArith & overflow;
	end

	// a subtract gives zero exactly when the operands match
	aZeroFlag: assert property (
		@(posedge clk) disable iff (!rstN)
		(aluControl == execPkg::aluSub) |-> (aluFlags[execPkg::flagZ] == (a == b))
	) else $error("Z flag %0b wrong for subtract of %0h and %0h",
		aluFlags[execPkg::flagZ], a, b);

endmodule

/* hdl/conditionUnit.sv */
/*
  Condition unit of the execute stage. Holds the NZCV flags register,
  checks the instruction's condition code against the flags stored
  before it, and gates the PC-source, register-write, memory-write
  and branch strobes with the result. When the condition passes, the
  fields chosen by flagWrite load from the ALU on the next clk edge.
*/
`timescale 1ns/1ps

module conditionUnit (
	input  logic clk,
	input  logic rstN,
	input  logic pcSrc,
	input  logic regWrite,
	input  logic memWrite,
	input  logic branch,
	input  logic [1:0] flagWrite,
	input  execPkg::condT cond,
	input  execPkg::flagsT aluFlags,
	output logic branchTaken,
	output logic pcSrcCond,
	output logic regWriteCond,
	output logic memWriteCond,
	output execPkg::flagsT flags
);

	logic condEx;
	logic nFlag;
	logic zFlag;
	logic cFlag;
	logic vFlag;

	// stored flags, before this instruction
	assign nFlag = flags[execPkg::flagN];
	assign zFlag = flags[execPkg::flagZ];
	assign cFlag = flags[execPkg::flagC];
	assign vFlag = flags[execPkg::flagV];

	always_comb begin
		case (cond)
			execPkg::condEq: condEx = zFlag;
			execPkg::condNe: condEx = ~zFlag;
			execPkg::condCs: condEx = cFlag;
			execPkg::condCc: condEx = ~cFlag;
			execPkg::condMi: condEx = nFlag;
			execPkg::condPl: condEx = ~nFlag;
			execPkg::condVs: condEx = vFlag;
			execPkg::condVc: condEx = ~vFlag;
			execPkg::condHi: condEx = cFlag & ~zFlag; // unsigned higher
			execPkg::condLs: condEx = ~cFlag | zFlag;
			execPkg::condGe: condEx = (nFlag == vFlag); // signed compare
			execPkg::condLt: condEx = (nFlag != vFlag);
			execPkg::condGt: condEx = ~zFlag & (nFlag == vFlag);
			execPkg::condLe: condEx = zFlag | (nFlag != vFlag);
			execPkg::condAl: condEx = 1'b1;
			default:         condEx = 1'b0; // reserved code never executes
		endcase
	end

	assign branchTaken = branch & condEx;
	assign pcSrcCond = pcSrc & condEx;
	assign regWriteCond = regWrite & condEx;
	assign memWriteCond = memWrite & condEx;

	// flags register, fields updated separately
	always_ff @(posedge clk) begin
		if (!rstN) begin
			flags <= '0;
		end else if (condEx) begin
			if (flagWrite[1]) begin // N and Z
				flags[execPkg::flagN] <= aluFlags[execPkg::flagN];
				flags[execPkg::flagZ] <= aluFlags[execPkg::flagZ];
			end
			if (flagWrite[0]) begin // C and V
				flags[execPkg::flagC] <= aluFlags[execPkg::flagC];
				flags[execPkg::flagV] <= aluFlags[execPkg::flagV];
			end
		end
	end

	// a failed instruction leaves the flags untouched
	aFlagsHold: assert property (
		@(posedge clk) disable iff (!rstN)
		!condEx |=> $stable(flags)
	) else $error("flags changed after failed condition");

endmodule

/* hdl/execPkg.sv */
/*
  Shared definitions for the execute stage: datapath width, the
  typedefs for words, register indices and NZCV flags, and the enums
  for ALU operations, forwarding selects and condition codes.
  Modules refer to these by execPkg::name.
*/
package execPkg;

	parameter int dataWidth = 24; // default datapath width

	// bit positions inside flagsT
	parameter int flagN = 3;
	parameter int flagZ = 2;
	parameter int flagC = 1;
	parameter int flagV = 0;

	typedef logic [dataWidth-1:0] wordT; // operand or result word
	typedef logic [3:0] regIdxT; // destination register index
	typedef logic [3:0] flagsT; // {N, Z, C, V}

	// flagWrite field (2 bits, not a typedef)
	//   bit 1 writes N and Z
	//   bit 0 writes C and V

	typedef enum logic [2:0] {
		aluAdd = 3'd0,
		aluSub = 3'd1,
		aluAnd = 3'd2,
		aluOrr = 3'd3,
		aluEor = 3'd4,
		aluBic = 3'd5, // a and not b
		aluMov = 3'd6, // b
		aluMvn = 3'd7  // not b
	} aluOpT;

	typedef enum logic [1:0] {
		fwdReg        = 2'd0, // register file value
		fwdResultW    = 2'd1, // writeback result
		fwdAluResultM = 2'd2  // memory stage ALU result, 3 is illegal
	} fwdSelT;

	typedef enum logic [3:0] {
		condEq, condNe, condCs, condCc, condMi, condPl, condVs, condVc,
		condHi, condLs, condGe, condLt, condGt, condLe, condAl,
		condRsvd // reserved, behaves as never
	} condT;

endpackage

/* hdl/executeMemReg.sv */
/*
  Execute-to-memory pipeline register. Captures the result, store
  data, destination index and gated control of one instruction each
  cycle, so its outputs show that instruction one clk later. A
  synchronous reset clears everything, so the memory stage sees no
  write right after reset.
*/
`timescale 1ns/1ps

module executeMemReg #(
	parameter int N = 24
) (
	input  logic clk,
	input  logic rstN,
	input  logic pcSrcCond,
	input  logic regWriteCond,
	input  logic memWriteCond,
	input  logic memtoReg,
	input  logic [N-1:0] aluResult,
	input  logic [N-1:0] writeData,
	input  execPkg::regIdxT wa3,
	output logic pcSrcM,
	output logic regWriteM,
	output logic memWriteM,
	output logic memtoRegM,
	output logic [N-1:0] aluResultM,
	output logic [N-1:0] writeDataM,
	output execPkg::regIdxT wa3M
);

	// control strobes
	always_ff @(posedge clk) begin
		if (!rstN) begin
			pcSrcM <= 1'b0;
			regWriteM <= 1'b0;
			memWriteM <= 1'b0;
			memtoRegM <= 1'b0;
		end else begin
			pcSrcM <= pcSrcCond;
			regWriteM <= regWriteCond;
			memWriteM <= memWriteCond;
			memtoRegM <= memtoReg;
		end
	end

	// data fields, also cleared on reset
	always_ff @(posedge clk) begin
		if (!rstN) begin
			aluResultM <= '0;
			writeDataM <= '0;
			wa3M <= '0;
		end else begin
			aluResultM <= aluResult;
			writeDataM <= writeData;
			wa3M <= wa3;
		end
	end

	aQuietAfterReset: assert property (
		@(posedge clk)
		!rstN |=> !(pcSrcM | regWriteM | memWriteM | memtoRegM)
	) else $error("memory stage strobe high after reset");

endmodule

/* hdl/executeStage.sv */
/*
  Execute stage of the 24-bit pipelined core. Connects the operand
  selector, the scalar ALU, the condition unit and the execute-to-
  memory register. The ALU result also goes back to fetch as
  aluResultF in the same cycle. N sets the datapath width.
*/
`timescale 1ns/1ps

module executeStage #(
	parameter int N = execPkg::dataWidth
) (
	input  logic clk,
	input  logic rstN,
	input  logic [N-1:0] rd1,
	input  logic [N-1:0] rd2,
	input  logic [N-1:0] extImm,
	input  logic [N-1:0] resultW,
	input  logic [N-1:0] aluResultMFb,
	input  logic pcSrc,
	input  logic regWrite,
	input  logic memtoReg,
	input  logic memWrite,
	input  logic branch,
	input  logic aluSrc,
	input  execPkg::aluOpT aluControl,
	input  logic [1:0] flagWrite,
	input  execPkg::condT cond,
	input  execPkg::regIdxT wa3,
	input  execPkg::fwdSelT forwardA,
	input  execPkg::fwdSelT forwardB,
	output logic pcSrcM,
	output logic regWriteM,
	output logic memWriteM,
	output logic memtoRegM,
	output logic branchTaken,
	output logic [N-1:0] aluResultM,
	output logic [N-1:0] writeDataM,
	output logic [N-1:0] aluResultF,
	output execPkg::regIdxT wa3M,
	output execPkg::flagsT flags
);

	logic [N-1:0] srcA;
	logic [N-1:0] srcB;
	logic [N-1:0] writeData; // forwarded rd2, store data
	execPkg::flagsT aluFlags;
	logic pcSrcCond;
	logic regWriteCond;
	logic memWriteCond;

	operandSelect #(.N(N)) uOperandSelect (
		.clk(clk),
		.rstN(rstN),
		.rd1(rd1),
		.rd2(rd2),
		.extImm(extImm),
		.resultW(resultW),
		.aluResultMFb(aluResultMFb),
		.forwardA(forwardA),
		.forwardB(forwardB),
		.aluSrc(aluSrc),
		.srcA(srcA),
		.srcB(srcB),
		.writeData(writeData)
	);

	alu #(.N(N)) uAlu (
		.clk(clk),
		.rstN(rstN),
		.a(srcA),
		.b(srcB),
		.aluControl(aluControl),
		.result(aluResultF), // same wire feeds fetch and the register
		.aluFlags(aluFlags)
	);

	conditionUnit uConditionUnit (
		.clk(clk),
		.rstN(rstN),
		.pcSrc(pcSrc),
		.regWrite(regWrite),
		.memWrite(memWrite),
		.branch(branch),
		.flagWrite(flagWrite),
		.cond(cond),
		.aluFlags(aluFlags),
		.branchTaken(branchTaken),
		.pcSrcCond(pcSrcCond),
		.regWriteCond(regWriteCond),
		.memWriteCond(memWriteCond),
		.flags(flags)
	);

	executeMemReg #(.N(N)) uExecuteMemReg (
		.clk(clk),
		.rstN(rstN),
		.pcSrcCond(pcSrcCond),
		.regWriteCond(regWriteCond),
		.memWriteCond(memWriteCond),
		.memtoReg(memtoReg),
		.aluResult(aluResultF),
		.writeData(writeData),
		.wa3(wa3),
		.pcSrcM(pcSrcM),
		.regWriteM(regWriteM),
		.memWriteM(memWriteM),
		.memtoRegM(memtoRegM),
		.aluResultM(aluResultM),
		.writeDataM(writeDataM),
		.wa3M(wa3M)
	);

endmodule

/* hdl/operandSelect.sv */
/*
  Operand selection for the execute stage. Each register operand can
  be replaced by the writeback result or the memory stage ALU result,
  then operand B picks between the forwarded second register and the
  extended immediate. The forwarded second register is the store data.
*/
`timescale 1ns/1ps

module operandSelect #(
	parameter int N = 24
) (
	input  logic clk,
	input  logic rstN,
	input  logic [N-1:0] rd1,
	input  logic [N-1:0] rd2,
	input  logic [N-1:0] extImm,
	input  logic [N-1:0] resultW,
	input  logic [N-1:0] aluResultMFb,
	input  execPkg::fwdSelT forwardA,
	input  execPkg::fwdSelT forwardB,
	input  logic aluSrc,
	output logic [N-1:0] srcA,
	output logic [N-1:0] srcB,
	output logic [N-1:0] writeData
);

	// forwarding mux for operand A
	always_comb begin
		case (forwardA)
			execPkg::fwdResultW:    srcA = resultW;
			execPkg::fwdAluResultM: srcA = aluResultMFb;
			default:                srcA = rd1; // fwdReg, illegal falls back
		endcase
	end

	// forwarding mux for the second register
	always_comb begin
		case (forwardB)
			execPkg::fwdResultW:    writeData = resultW;
			execPkg::fwdAluResultM: writeData = aluResultMFb;
			default:                writeData = rd2;
		endcase
	end

	assign srcB = aluSrc ? extImm : writeData; // immediate or register

	// the hazard unit must never drive the unused select code
	aIllegalFwd: assert property (
		@(posedge clk) disable iff (!rstN)
		(forwardA != 2'd3) && (forwardB != 2'd3)
	) else $error("illegal forwarding select A=%0h B=%0h", forwardA, forwardB);

endmodule
